/* design/proc_cfg.svh */
// Sizing macros for the proc core, included by the RTL and the testbench model
`default_nettype none

`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Machine word, also the PC width
`define PROC_DATA_WIDTH 16

// General register file
`define PROC_REG_COUNT 8
`define PROC_REG_ADDR_WIDTH 3

// Data RAM size in words
`define PROC_DMEM_DEPTH 256

// PC value after reset
`define PROC_RESET_PC 16'h0000

`endif

`default_nettype wire

/* design/isaPkg.sv */
// Instruction encodings and field types, shared by the decoder and the testbench model
`include "proc_cfg.svh"
`default_nettype none

package isaPkg;

   // Field layout of a 16-bit instruction
   //   [15:11] opcode
   //   [10:8]  rs
   //   [7:5]   rt
   //   [4:2]   rd, R-type only
   //   [1:0]   func, R-type only
   //   [4:0]   imm5 for ADDI, LD, ST
   //   [7:0]   imm8 for LBI, BEQZ, BNEZ
   //   [10:0]  imm11 for J
   // Destination register
   //   R-type writes rd
   //   ADDI and LD write the rt position
   //   LBI writes the rs position
   // ST stores rt at rs + imm5, branches test rs
   // SUB computes rs - rt
   // Branch and jump targets are PC + 1 + offset
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100,
      OP_ADDI  = 5'b01000,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_LBI   = 5'b11000,
      OP_RTYPE = 5'b11011
   } opcodeT;

   // R-type operation select
   typedef enum logic [1:0] {
      FN_ADD = 2'b00,
      FN_SUB = 2'b01,
      FN_AND = 2'b11,
      FN_XOR = 2'b10
   } funcT;

   typedef logic [`PROC_REG_ADDR_WIDTH-1:0] regIdxT;

endpackage

`default_nettype wire

/* design/ctrlPkg.sv */
// Control encodings passed from decode to execute and memory
`default_nettype none

package ctrlPkg;

   // ALU function, PASSB forwards operand B untouched
   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_SUB   = 3'd1,
      ALU_AND   = 3'd2,
      ALU_XOR   = 3'd3,
      ALU_PASSB = 3'd4
   } aluOpT;

   // Write-back source
   typedef enum logic {
      WB_ALU = 1'b0,
      WB_MEM = 1'b1
   } wbSelT;

   // PC redirect condition, tested on rs
   typedef enum logic [1:0] {
      BR_NONE   = 2'd0,
      BR_EQZ    = 2'd1,
      BR_NEZ    = 2'd2,
      BR_ALWAYS = 2'd3
   } brCondT;

endpackage

`default_nettype wire

/* design/fetch.sv */
// PC register with next-PC select and sticky halt, drives the instruction fetch address
`timescale 1ns/100ps
`include "proc_cfg.svh"
`default_nettype none

module fetch (
   input  wire                         clk,
   input  wire                         rstN,
   input  wire                         halt,
   input  wire                         takeBranch,
   input  wire  [`PROC_DATA_WIDTH-1:0] pcTarget,
   output logic [`PROC_DATA_WIDTH-1:0] pc,
   output logic                        halted
);

   // Set by the first HALT, cleared only by reset
   logic haltFlag;

   // Halt shows up in the same cycle the HALT word is decoded
   assign halted = haltFlag | halt;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc       <= `PROC_RESET_PC;
         haltFlag <= 1'b0;
      end else begin
         if (halt) begin
            haltFlag <= 1'b1;
         end
         // PC parks on the HALT word
         if (!halted) begin
            pc <= takeBranch ? pcTarget : pc + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* design/regFile.sv */
// Eight-entry general register file, two async read ports and one clocked write port
`timescale 1ns/100ps
`include "proc_cfg.svh"
`default_nettype none

module regFile (
   input  wire                         clk,
   input  wire                         rstN,
   input  wire  isaPkg::regIdxT        readReg1,
   input  wire  isaPkg::regIdxT        readReg2,
   input  wire                         writeEn,
   input  wire  isaPkg::regIdxT        writeReg,
   input  wire  [`PROC_DATA_WIDTH-1:0] writeData,
   output logic [`PROC_DATA_WIDTH-1:0] read1Data,
   output logic [`PROC_DATA_WIDTH-1:0] read2Data
);

   logic [`PROC_DATA_WIDTH-1:0] regs [`PROC_REG_COUNT];

   // Register 0 is an ordinary register here
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `PROC_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeReg] <= writeData;
      end
   end

   // No bypass, a read in the writing cycle sees the old value
   assign read1Data = regs[readReg1];
   assign read2Data = regs[readReg2];

endmodule

`default_nettype wire

/* design/decode.sv */
// Instruction decoder, builds the control word and immediate and owns the register file
`timescale 1ns/100ps
`include "proc_cfg.svh"
`default_nettype none

module decode (
   input  wire                         clk,
   input  wire                         rstN,
   input  wire  [`PROC_DATA_WIDTH-1:0] instr,
   input  wire  [`PROC_DATA_WIDTH-1:0] writeData,
   output logic [`PROC_DATA_WIDTH-1:0] read1Data,
   output logic [`PROC_DATA_WIDTH-1:0] read2Data,
   output logic [`PROC_DATA_WIDTH-1:0] immVal,
   output ctrlPkg::aluOpT              aluOp,
   output logic                        aluSrc,
   output ctrlPkg::brCondT             brCond,
   output logic                        memWrite,
   output ctrlPkg::wbSelT              wbSel,
   output logic                        regWrite,
   output isaPkg::regIdxT              writeReg,
   output logic                        halt,
   output logic                        err
);

   isaPkg::opcodeT              opcode;
   isaPkg::funcT                func;
   isaPkg::regIdxT              rs;
   isaPkg::regIdxT              rt;
   isaPkg::regIdxT              rd;
   logic [`PROC_DATA_WIDTH-1:0] imm5Ext;
   logic [`PROC_DATA_WIDTH-1:0] imm8Ext;
   logic [`PROC_DATA_WIDTH-1:0] imm11Ext;

   // Field split
   assign opcode = isaPkg::opcodeT'(instr[15:11]);
   assign func   = isaPkg::funcT'(instr[1:0]);
   assign rs     = instr[10:8];
   assign rt     = instr[7:5];
   assign rd     = instr[4:2];

   // Sign extension of the three immediate widths
   assign imm5Ext  = {{(`PROC_DATA_WIDTH-5){instr[4]}}, instr[4:0]};
   assign imm8Ext  = {{(`PROC_DATA_WIDTH-8){instr[7]}}, instr[7:0]};
   assign imm11Ext = {{(`PROC_DATA_WIDTH-11){instr[10]}}, instr[10:0]};

   // rs feeds ALU operand A and the zero test, rt is operand B and store data
   regFile regBank (
      .clk       (clk),
      .rstN      (rstN),
      .readReg1  (rs),
      .readReg2  (rt),
      .writeEn   (regWrite),
      .writeReg  (writeReg),
      .writeData (writeData),
      .read1Data (read1Data),
      .read2Data (read2Data)
   );

   always_comb begin
      // Defaults behave as a NOP
      aluOp    = ctrlPkg::ALU_ADD;
      aluSrc   = 1'b0;
      brCond   = ctrlPkg::BR_NONE;
      memWrite = 1'b0;
      wbSel    = ctrlPkg::WB_ALU;
      regWrite = 1'b0;
      writeReg = rd;
      immVal   = imm5Ext;
      halt     = 1'b0;
      err      = 1'b0;
      case (opcode)
         isaPkg::OP_NOP: begin
         end
         isaPkg::OP_HALT: begin
            halt = 1'b1;
         end
         isaPkg::OP_RTYPE: begin
            regWrite = 1'b1;
            case (func)
               isaPkg::FN_ADD: aluOp = ctrlPkg::ALU_ADD;
               isaPkg::FN_SUB: aluOp = ctrlPkg::ALU_SUB;
               isaPkg::FN_AND: aluOp = ctrlPkg::ALU_AND;
               isaPkg::FN_XOR: aluOp = ctrlPkg::ALU_XOR;
               default: begin
                  // Unknown func, no write
                  regWrite = 1'b0;
                  err      = 1'b1;
               end
            endcase
         end
         isaPkg::OP_ADDI: begin
            aluSrc   = 1'b1;
            regWrite = 1'b1;
            writeReg = rt;
         end
         isaPkg::OP_LBI: begin
            // Immediate straight through the ALU into rs
            aluOp    = ctrlPkg::ALU_PASSB;
            aluSrc   = 1'b1;
            immVal   = imm8Ext;
            regWrite = 1'b1;
            writeReg = rs;
         end
         isaPkg::OP_LD: begin
            aluSrc   = 1'b1;
            wbSel    = ctrlPkg::WB_MEM;
            regWrite = 1'b1;
            writeReg = rt;
         end
         isaPkg::OP_ST: begin
            aluSrc   = 1'b1;
            memWrite = 1'b1;
         end
         isaPkg::OP_BEQZ: begin
            brCond = ctrlPkg::BR_EQZ;
            immVal = imm8Ext;
         end
         isaPkg::OP_BNEZ: begin
            brCond = ctrlPkg::BR_NEZ;
            immVal = imm8Ext;
         end
         isaPkg::OP_J: begin
            brCond = ctrlPkg::BR_ALWAYS;
            immVal = imm11Ext;
         end
         // Unassigned opcode, executes as NOP
         default: err = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

/* design/execute.sv */
// ALU, load/store address generation and branch/jump resolution
`timescale 1ns/100ps
`include "proc_cfg.svh"
`default_nettype none

module execute (
   input  wire  [`PROC_DATA_WIDTH-1:0] pc,
   input  wire  [`PROC_DATA_WIDTH-1:0] read1Data,
   input  wire  [`PROC_DATA_WIDTH-1:0] read2Data,
   input  wire  [`PROC_DATA_WIDTH-1:0] immVal,
   input  wire  ctrlPkg::aluOpT        aluOp,
   input  wire                         aluSrc,
   input  wire  ctrlPkg::brCondT       brCond,
   output logic [`PROC_DATA_WIDTH-1:0] aluOut,
   output logic [`PROC_DATA_WIDTH-1:0] pcTarget,
   output logic                        takeBranch
);

   logic [`PROC_DATA_WIDTH-1:0] opB;
   logic                        rsZero;

   // Operand B from rt or the extended immediate
   assign opB = aluSrc ? immVal : read2Data;

   // Also forms rs + offset for LD and ST
   always_comb begin
      case (aluOp)
         ctrlPkg::ALU_ADD:   aluOut = read1Data + opB;
         ctrlPkg::ALU_SUB:   aluOut = read1Data - opB;
         ctrlPkg::ALU_AND:   aluOut = read1Data & opB;
         ctrlPkg::ALU_XOR:   aluOut = read1Data ^ opB;
         ctrlPkg::ALU_PASSB: aluOut = opB;
         default:            aluOut = '0;
      endcase
   end

   // Relative to the following instruction
   assign pcTarget = pc + 1'b1 + immVal;

   assign rsZero = (read1Data == '0);

   always_comb begin
      unique case (brCond)
         ctrlPkg::BR_NONE:   takeBranch = 1'b0;
         ctrlPkg::BR_EQZ:    takeBranch = rsZero;
         ctrlPkg::BR_NEZ:    takeBranch = !rsZero;
         ctrlPkg::BR_ALWAYS: takeBranch = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

/* design/memory.sv */
// Word-addressed data RAM with clocked store, async load and the write-back select
`timescale 1ns/100ps
`include "proc_cfg.svh"
`default_nettype none

module memory (
   input  wire                         clk,
   input  wire  [`PROC_DATA_WIDTH-1:0] aluOut,
   input  wire  [`PROC_DATA_WIDTH-1:0] storeData,
   input  wire                         memWrite,
   input  wire  ctrlPkg::wbSelT        wbSel,
   output logic [`PROC_DATA_WIDTH-1:0] writeData
);

   localparam int addrWidth = $clog2(`PROC_DMEM_DEPTH);

   logic [`PROC_DATA_WIDTH-1:0] ram [`PROC_DMEM_DEPTH];
   logic [addrWidth-1:0]        addr;
   logic [`PROC_DATA_WIDTH-1:0] loadData;

   // Upper address bits ignored, the RAM wraps
   assign addr = aluOut[addrWidth-1:0];

   always_ff @(posedge clk) begin
      if (memWrite) begin
         ram[addr] <= storeData;
      end
   end

   assign loadData = ram[addr];

   // Loaded word for LD, ALU result otherwise
   assign writeData = (wbSel == ctrlPkg::WB_MEM) ? loadData : aluOut;

endmodule

`default_nettype wire

/* design/proc.sv */
// Top level of the single-cycle core, chains fetch, decode, execute and memory
`timescale 1ns/100ps
`include "proc_cfg.svh"
`default_nettype none

module proc (
   input  wire                         clk,
   input  wire                         rstN,
   input  wire  [`PROC_DATA_WIDTH-1:0] instr,
   output logic [`PROC_DATA_WIDTH-1:0] pc,
   output logic                        wbEn,
   output isaPkg::regIdxT              wbReg,
   output logic [`PROC_DATA_WIDTH-1:0] wbData,
   output logic                        halted,
   output logic                        err
);

   // Decode outputs
   logic [`PROC_DATA_WIDTH-1:0] read1Data;
   logic [`PROC_DATA_WIDTH-1:0] read2Data;
   logic [`PROC_DATA_WIDTH-1:0] immVal;
   ctrlPkg::aluOpT              aluOp;
   logic                        aluSrc;
   ctrlPkg::brCondT             brCond;
   logic                        memWrite;
   ctrlPkg::wbSelT              wbSel;
   logic                        regWrite;
   isaPkg::regIdxT              writeReg;
   logic                        halt;
   // Execute outputs
   logic [`PROC_DATA_WIDTH-1:0] aluOut;
   logic [`PROC_DATA_WIDTH-1:0] pcTarget;
   logic                        takeBranch;
   // Write-back value, also the trace data
   logic [`PROC_DATA_WIDTH-1:0] writeData;

   fetch fetchStage (
      .clk        (clk),
      .rstN       (rstN),
      .halt       (halt),
      .takeBranch (takeBranch),
      .pcTarget   (pcTarget),
      .pc         (pc),
      .halted     (halted)
   );

   decode decodeStage (
      .clk       (clk),
      .rstN      (rstN),
      .instr     (instr),
      .writeData (writeData),
      .read1Data (read1Data),
      .read2Data (read2Data),
      .immVal    (immVal),
      .aluOp     (aluOp),
      .aluSrc    (aluSrc),
      .brCond    (brCond),
      .memWrite  (memWrite),
      .wbSel     (wbSel),
      .regWrite  (regWrite),
      .writeReg  (writeReg),
      .halt      (halt),
      .err       (err)
   );

   execute executeStage (
      .pc         (pc),
      .read1Data  (read1Data),
      .read2Data  (read2Data),
      .immVal     (immVal),
      .aluOp      (aluOp),
      .aluSrc     (aluSrc),
      .brCond     (brCond),
      .aluOut     (aluOut),
      .pcTarget   (pcTarget),
      .takeBranch (takeBranch)
   );

   // rt supplies the store data
   memory memoryStage (
      .clk       (clk),
      .aluOut    (aluOut),
      .storeData (read2Data),
      .memWrite  (memWrite),
      .wbSel     (wbSel),
      .writeData (writeData)
   );

   // Trace of the write taken at the coming edge
   assign wbEn   = regWrite & ~halted;
   assign wbReg  = writeReg;
   assign wbData = writeData;

endmodule

`default_nettype wire

/* testbench/procChecker.sv */
// Architectural model of the proc ISA, compares the DUT trace ports at every rising edge
`timescale 1ns/100ps
`include "proc_cfg.svh"
`default_nettype none

module procChecker (
   input  wire                         clk,
   input  wire                         rstN,
   input  wire  [`PROC_DATA_WIDTH-1:0] instr,
   input  wire  [`PROC_DATA_WIDTH-1:0] pc,
   input  wire                         wbEn,
   input  wire  isaPkg::regIdxT        wbReg,
   input  wire  [`PROC_DATA_WIDTH-1:0] wbData,
   input  wire                         halted,
   input  wire                         err,
   output int                          errorCount
);

   // Model state
   logic [`PROC_DATA_WIDTH-1:0] regs [`PROC_REG_COUNT];
   logic [`PROC_DATA_WIDTH-1:0] mem [`PROC_DMEM_DEPTH];
   logic [`PROC_DATA_WIDTH-1:0] modelPc;
   logic                        modelHalted;

   initial errorCount = 0;

   task automatic compareValue(input string name, input logic [`PROC_DATA_WIDTH-1:0] expVal,
                               input logic [`PROC_DATA_WIDTH-1:0] actVal);
      if (actVal !== expVal) begin
         errorCount++;
         $display("[FAIL] time %0t: %s expected 0x%h, got 0x%h", $time, name, expVal, actVal);
      end
   endtask

   // Outputs still hold the pre-edge values here
   always @(posedge clk) begin : predictCycle
      logic [`PROC_DATA_WIDTH-1:0] opA;
      logic [`PROC_DATA_WIDTH-1:0] opB;
      logic [`PROC_DATA_WIDTH-1:0] imm5;
      logic [`PROC_DATA_WIDTH-1:0] imm8;
      logic [`PROC_DATA_WIDTH-1:0] imm11;
      logic [`PROC_DATA_WIDTH-1:0] addrSum;
      logic [`PROC_DATA_WIDTH-1:0] expWbData;
      logic [`PROC_DATA_WIDTH-1:0] nextPc;
      logic [2:0]                  expWbReg;
      logic                        expWbEn;
      logic                        expErr;
      logic                        haltNow;
      logic                        doStore;
      int                          memIdx;
      if (!rstN) begin
         modelPc     = `PROC_RESET_PC;
         modelHalted = 1'b0;
         for (int i = 0; i < `PROC_REG_COUNT; i++) begin
            regs[i] = '0;
         end
      end else begin
         opA     = regs[instr[10:8]];
         opB     = regs[instr[7:5]];
         imm5    = {{11{instr[4]}}, instr[4:0]};
         imm8    = {{8{instr[7]}}, instr[7:0]};
         imm11   = {{5{instr[10]}}, instr[10:0]};
         addrSum = opA + imm5;
         memIdx  = addrSum % `PROC_DMEM_DEPTH;
         // Default is a plain step with no side effect
         expWbEn   = 1'b0;
         expWbReg  = '0;
         expWbData = '0;
         expErr    = 1'b0;
         doStore   = 1'b0;
         haltNow   = modelHalted;
         nextPc    = modelPc + 1'b1;
         if (modelHalted) begin
            nextPc = modelPc;
         end else begin
            case (instr[15:11])
               isaPkg::OP_NOP: begin
               end
               isaPkg::OP_HALT: begin
                  haltNow = 1'b1;
                  nextPc  = modelPc;
               end
               isaPkg::OP_RTYPE: begin
                  expWbEn  = 1'b1;
                  expWbReg = instr[4:2];
                  case (instr[1:0])
                     isaPkg::FN_ADD: expWbData = opA + opB;
                     isaPkg::FN_SUB: expWbData = opA - opB;
                     isaPkg::FN_AND: expWbData = opA & opB;
                     default:        expWbData = opA ^ opB;
                  endcase
               end
               isaPkg::OP_ADDI: begin
                  expWbEn   = 1'b1;
                  expWbReg  = instr[7:5];
                  expWbData = opA + imm5;
               end
               isaPkg::OP_LBI: begin
                  expWbEn   = 1'b1;
                  expWbReg  = instr[10:8];
                  expWbData = imm8;
               end
               isaPkg::OP_LD: begin
                  expWbEn   = 1'b1;
                  expWbReg  = instr[7:5];
                  expWbData = mem[memIdx];
               end
               isaPkg::OP_ST: doStore = 1'b1;
               isaPkg::OP_BEQZ: begin
                  if (opA == '0) nextPc = modelPc + 1'b1 + imm8;
               end
               isaPkg::OP_BNEZ: begin
                  if (opA != '0) nextPc = modelPc + 1'b1 + imm8;
               end
               isaPkg::OP_J: nextPc = modelPc + 1'b1 + imm11;
               default: expErr = 1'b1;
            endcase
         end
         compareValue("pc", modelPc, pc);
         compareValue("halted", haltNow, halted);
         compareValue("err", expErr, err);
         compareValue("wbEn", expWbEn, wbEn);
         // Destination and data only matter on a write
         if (expWbEn) begin
            compareValue("wbReg", expWbReg, wbReg);
            compareValue("wbData", expWbData, wbData);
         end
         // Commit the instruction to the model
         if (expWbEn) regs[expWbReg] = expWbData;
         if (doStore) mem[memIdx] = opB;
         modelPc     = nextPc;
         modelHalted = haltNow;
      end
   end

endmodule

`default_nettype wire

/* testbench/proc_sva.sv */
// Concurrent assertions on the proc trace outputs, attached to every proc instance by bind
`timescale 1ns/100ps
`include "proc_cfg.svh"
`default_nettype none

module proc_sva (
   input wire                        clk,
   input wire                        rstN,
   input wire [`PROC_DATA_WIDTH-1:0] pc,
   input wire                        halted,
   input wire                        wbEn,
   input wire                        err,
   input wire                        regWrite
);

   // Read by the testbench summary
   int failCount = 0;

   // PC parks on the HALT word until reset
   pcHoldsWhileHalted: assert property (@(posedge clk) disable iff (!rstN)
      halted |=> $stable(pc))
      else begin
         failCount++;
         $error("pc changed while the core was halted");
      end

   // No register write in reset or after HALT
   noWriteInResetOrHalt: assert property (@(posedge clk)
      (!rstN || halted) |-> !wbEn)
      else begin
         failCount++;
         $error("wbEn high during reset or while halted");
      end

   // Illegal word behaves as NOP
   errBlocksWrite: assert property (@(posedge clk)
      err |-> !regWrite)
      else begin
         failCount++;
         $error("register write enabled on an illegal instruction");
      end

endmodule

bind proc proc_sva procAssert (
   .clk      (clk),
   .rstN     (rstN),
   .pc       (pc),
   .halted   (halted),
   .wbEn     (wbEn),
   .err      (err),
   .regWrite (regWrite)
);

`default_nettype wire

/* testbench/proc_tb.sv */
// Testbench top for proc, builds a random program per test, serves fetches and reports results
`timescale 1ns/100ps
`include "proc_cfg.svh"
`default_nettype none

module proc_tb;

   localparam int numTests   = 5;
   localparam int progLen    = 32;
   // Reset, program and tail cycles per test
   localparam int cycleLimit = numTests * (progLen + 10 + 20);
   localparam logic [`PROC_DATA_WIDTH-1:0] haltWord = {isaPkg::OP_HALT, 11'd0};
   localparam logic [`PROC_DATA_WIDTH-1:0] nopWord  = {isaPkg::OP_NOP, 11'd0};

   logic                        clk;
   logic                        rstN;
   logic [`PROC_DATA_WIDTH-1:0] instr;
   logic [`PROC_DATA_WIDTH-1:0] pc;
   logic                        wbEn;
   isaPkg::regIdxT              wbReg;
   logic [`PROC_DATA_WIDTH-1:0] wbData;
   logic                        halted;
   logic                        err;
   int                          errorCount;
   int                          seed;
   int                          cycleCount = 0;
   int                          passedTests;
   // Instruction memory image of the current test
   logic [`PROC_DATA_WIDTH-1:0] prog [progLen];
   string testNames [numTests] = '{"alu", "immediate", "memory", "branch", "halt/illegal"};

   proc DUT (
      .clk    (clk),
      .rstN   (rstN),
      .instr  (instr),
      .pc     (pc),
      .wbEn   (wbEn),
      .wbReg  (wbReg),
      .wbData (wbData),
      .halted (halted),
      .err    (err)
   );

   procChecker modelCheck (
      .clk        (clk),
      .rstN       (rstN),
      .instr      (instr),
      .pc         (pc),
      .wbEn       (wbEn),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .halted     (halted),
      .err        (err),
      .errorCount (errorCount)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout: the processor never halted within %0d cycles", cycleLimit);
         $display("tests failed");
         $finish;
      end
   end

   function automatic int randBelow(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [15:0] rTypeWord(input int func, input int rs, input int rt,
                                             input int rd);
      return {isaPkg::OP_RTYPE, 3'(rs), 3'(rt), 3'(rd), 2'(func)};
   endfunction

   // ADDI, LD and ST share the rs, rt, imm5 layout
   function automatic logic [15:0] imm5Word(input isaPkg::opcodeT op, input int rs, input int rt,
                                            input int imm);
      return {op, 3'(rs), 3'(rt), 5'(imm)};
   endfunction

   // LBI and the two branches
   function automatic logic [15:0] imm8Word(input isaPkg::opcodeT op, input int rs,
                                            input int imm);
      return {op, 3'(rs), 8'(imm)};
   endfunction

   function automatic bit isLegalOpcode(input logic [4:0] op);
      case (op)
         isaPkg::OP_NOP, isaPkg::OP_HALT, isaPkg::OP_RTYPE, isaPkg::OP_ADDI,
         isaPkg::OP_LBI, isaPkg::OP_LD, isaPkg::OP_ST, isaPkg::OP_BEQZ,
         isaPkg::OP_BNEZ, isaPkg::OP_J: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // Past the image the fetch port sees HALT
   function automatic logic [15:0] fetchWord(input logic [`PROC_DATA_WIDTH-1:0] addr);
      if (addr < progLen) return prog[addr];
      return haltWord;
   endfunction

   function automatic void buildProgram(input int kind);
      int offsets[$];
      int off;
      int rt;
      logic [15:0] word;
      for (int i = 0; i < progLen; i++) prog[i] = haltWord;
      case (kind)
         0: begin
            // Seed all registers, then random R-type
            for (int r = 0; r < `PROC_REG_COUNT; r++) begin
               prog[r] = imm8Word(isaPkg::OP_LBI, r, randBelow(256));
            end
            for (int i = `PROC_REG_COUNT; i < progLen - 1; i++) begin
               prog[i] = rTypeWord(randBelow(4), randBelow(8), randBelow(8), randBelow(8));
            end
         end
         1: begin
            for (int i = 0; i < progLen - 1; i++) begin
               if (randBelow(2) == 0) begin
                  prog[i] = imm8Word(isaPkg::OP_LBI, randBelow(8), randBelow(256));
               end else begin
                  prog[i] = imm5Word(isaPkg::OP_ADDI, randBelow(8), randBelow(8),
                                     randBelow(32) - 16);
               end
            end
         end
         2: begin
            // r6 is the base register, loads only hit stored offsets
            for (int r = 0; r < `PROC_REG_COUNT; r++) begin
               prog[r] = imm8Word(isaPkg::OP_LBI, r, randBelow(128));
            end
            for (int i = `PROC_REG_COUNT; i < progLen - 1; i++) begin
               if (offsets.size() == 0 || randBelow(2) == 0) begin
                  off = randBelow(32) - 16;
                  offsets.push_back(off);
                  prog[i] = imm5Word(isaPkg::OP_ST, 6, randBelow(8), off);
               end else begin
                  rt = randBelow(7);
                  if (rt == 6) rt = 7;
                  off = offsets[randBelow(offsets.size())];
                  prog[i] = imm5Word(isaPkg::OP_LD, 6, rt, off);
               end
            end
         end
         3: begin
            // Small LBI values so both branch outcomes occur, offsets stay forward
            for (int i = 0; i < progLen - 1; i++) begin
               case (randBelow(5))
                  0: prog[i] = imm8Word(isaPkg::OP_LBI, randBelow(8), randBelow(2));
                  1: prog[i] = imm8Word(isaPkg::OP_BEQZ, randBelow(8), randBelow(4));
                  2: prog[i] = imm8Word(isaPkg::OP_BNEZ, randBelow(8), randBelow(4));
                  3: prog[i] = {isaPkg::OP_J, 11'(randBelow(4))};
                  default: begin
                     prog[i] = imm5Word(isaPkg::OP_ADDI, randBelow(8), randBelow(8),
                                        randBelow(32) - 16);
                  end
               endcase
            end
         end
         default: begin
            for (int i = 0; i < progLen - 1; i++) begin
               case (randBelow(4))
                  0: prog[i] = imm8Word(isaPkg::OP_LBI, randBelow(8), randBelow(256));
                  1: prog[i] = rTypeWord(randBelow(4), randBelow(8), randBelow(8), randBelow(8));
                  default: begin
                     word = 16'($random(seed));
                     while (isLegalOpcode(word[15:11])) word = 16'($random(seed));
                     prog[i] = word;
                  end
               endcase
            end
         end
      endcase
   endfunction

   initial begin
      int failsBefore;
      int testFails;
      seed        = 75703;
      passedTests = 0;
      rstN        = 1'b0;
      instr       = nopWord;
      for (int t = 0; t < numTests; t++) begin
         // Every edge from here on counts against this test
         failsBefore = errorCount + DUT.procAssert.failCount;
         @(negedge clk);
         rstN  = 1'b0;
         instr = nopWord;
         buildProgram(t);
         repeat (10) @(negedge clk);
         rstN  = 1'b1;
         instr = fetchWord(pc);
         @(posedge clk);
         while (!halted) begin
            @(negedge clk);
            instr = fetchWord(pc);
            @(posedge clk);
         end
         // A few cycles parked on HALT
         repeat (3) begin
            @(negedge clk);
            instr = fetchWord(pc);
         end
         @(negedge clk);
         testFails = errorCount + DUT.procAssert.failCount - failsBefore;
         if (testFails == 0) begin
            passedTests++;
            $display("test %0d %s: ok", t, testNames[t]);
         end else begin
            $display("test %0d %s: %0d mismatches", t, testNames[t], testFails);
         end
      end
      $display("%0d of %0d tests ok, %0d checker mismatches, %0d assertion failures",
               passedTests, numTests, errorCount, DUT.procAssert.failCount);
      if (passedTests == numTests) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/fetch.sv
design/regFile.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/proc.sv
testbench/procChecker.sv
testbench/proc_sva.sv
testbench/proc_tb.sv
